// ==== cache_pkg.sv ====
package cache_pkg;

    // cpu address, one word.
    localparam int ADDR_WIDTH = 32;

    // one cache block is four words.
    localparam int BLOCK_WIDTH = 128;

    localparam int BYTE_MASK_WIDTH = BLOCK_WIDTH / 8;

    // byte offset inside a block, the set index sits just above it.
    localparam int BLOCK_OFFSET_WIDTH = $clog2(BYTE_MASK_WIDTH);

    // two bits of port id, so at most four ways.
    localparam int PORT_ID_WIDTH = 2;

    typedef logic [PORT_ID_WIDTH-1:0] port_id_t;

    // request from a way to the store, 181 bits.
    typedef struct packed
    {
        logic                       valid;
        logic                       cacheable;
        logic                       write;
        port_id_t                   port;
        logic [BYTE_MASK_WIDTH-1:0] byte_mask;
        logic [BLOCK_WIDTH-1:0]     data;
        logic [ADDR_WIDTH-1:0]      addr;
    } req_packet_t;

    // read return from the store, 131 bits.
    typedef struct packed
    {
        logic                   valid;
        port_id_t               port;
        logic [BLOCK_WIDTH-1:0] data;
    } ret_packet_t;

endpackage

// ==== cache_req_if.sv ====
interface cache_req_if import cache_pkg::*; ();

    // req.valid stays up with stable fields until ack.
    req_packet_t req;
    logic        ack;

    modport arbiter
    (
        output req,
        input  ack
    );

    modport store
    (
        input  req,
        output ack
    );

endinterface

// ==== cache_ret_if.sv ====
interface cache_ret_if import cache_pkg::*; ();

    ret_packet_t ret;
    logic        ack; // transfer on an edge with ret.valid and ack both high.

    modport store
    (
        output ret,
        input  ack
    );

    modport router
    (
        input  ret,
        output ack
    );

endinterface

// ==== request_arbiter.sv ====
module request_arbiter import cache_pkg::*;
#(
    parameter int NUM_WAY = 2
)
(
    input  req_packet_t        req_in [NUM_WAY],
    output logic [NUM_WAY-1:0] req_ack,
    cache_req_if.arbiter       mem
);

    logic [NUM_WAY-1:0] valid_vec;
    logic [NUM_WAY-1:0] grant;

    always_comb
    begin
        for (int w = 0; w < NUM_WAY; w++)
        begin
            valid_vec[w] = req_in[w].valid;
        end
    end

    // lowest numbered valid way wins.
    // a request is held until acked, so the grant cannot move mid-request.
    always_comb
    begin
        grant = '0;
        for (int w = NUM_WAY - 1; w >= 0; w--)
        begin
            if (valid_vec[w])
            begin
                grant    = '0;
                grant[w] = 1'b1;
            end
        end
    end

    always_comb
    begin
        mem.req = '0; // idle bus when nobody asks.
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (grant[w])
            begin
                mem.req = req_in[w];
            end
        end
    end

    assign req_ack = grant & {NUM_WAY{mem.ack}}; // only the granted way sees the ack.

endmodule

// ==== block_store.sv ====
module block_store import cache_pkg::*;
#(
    parameter int NUM_SETS = 16
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   stall,
    cache_req_if.store             req,
    cache_ret_if.store             ret,
    input  logic [ADDR_WIDTH-1:0]  peek_addr,
    output logic [BLOCK_WIDTH-1:0] peek_data
);

    localparam int SET_INDEX_WIDTH = $clog2(NUM_SETS);

    logic [BLOCK_WIDTH-1:0]     blocks [NUM_SETS];
    logic [SET_INDEX_WIDTH-1:0] req_set;
    logic [SET_INDEX_WIDTH-1:0] peek_set;
    logic                       accept;
    logic                       ret_valid;
    port_id_t                   ret_port;
    logic [BLOCK_WIDTH-1:0]     ret_data;

    assign req_set  = req.req.addr[BLOCK_OFFSET_WIDTH +: SET_INDEX_WIDTH];
    assign peek_set = peek_addr[BLOCK_OFFSET_WIDTH +: SET_INDEX_WIDTH];

    // busy bank or an unreturned read holds the request off.
    assign req.ack = ~stall & ~ret_valid;
    assign accept  = req.req.valid & req.ack;

    // masked write, only flagged bytes change.
    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            for (int s = 0; s < NUM_SETS; s++)
            begin
                blocks[s] <= '0;
            end
        end
        else if (accept && req.req.write)
        begin
            for (int b = 0; b < BYTE_MASK_WIDTH; b++)
            begin
                if (req.req.byte_mask[b])
                begin
                    blocks[req_set][b*8 +: 8] <= req.req.data[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            ret_valid <= 1'b0;
        end
        else if (accept && !req.req.write)
        begin
            ret_valid <= 1'b1;
        end
        else if (ret_valid && ret.ack)
        begin
            ret_valid <= 1'b0; // return taken by the router.
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (accept && !req.req.write)
        begin
            ret_port <= req.req.port;
            ret_data <= blocks[req_set];
        end
    end

    assign ret.ret   = '{valid: ret_valid, port: ret_port, data: ret_data};
    assign peek_data = blocks[peek_set]; // back door, no handshake.

endmodule

// ==== return_router.sv ====
module return_router import cache_pkg::*;
#(
    parameter int NUM_WAY = 2
)
(
    cache_ret_if.router        ret,
    output ret_packet_t        ret_out [NUM_WAY],
    input  logic [NUM_WAY-1:0] ret_ack
);

    logic [NUM_WAY-1:0] hit;

    // which way the pending return belongs to.
    always_comb
    begin
        for (int w = 0; w < NUM_WAY; w++)
        begin
            hit[w] = ret.ret.valid && (ret.ret.port == port_id_t'(w));
        end
    end

    always_comb
    begin
        for (int w = 0; w < NUM_WAY; w++)
        begin
            if (hit[w])
            begin
                ret_out[w] = ret.ret;
            end
            else
            begin
                ret_out[w] = '0; // other ways see nothing.
            end
        end
    end

    assign ret.ack = |(hit & ret_ack); // only the addressed way can ack.

endmodule

// ==== cache_packet_generator.sv ====
module cache_packet_generator import cache_pkg::*;
#(
    parameter int NUM_WAY        = 2,
    parameter int TIMEOUT_CYCLES = 100000
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   start,
    input  logic [BLOCK_WIDTH-1:0] pattern,
    input  logic [ADDR_WIDTH-1:0]  base_addr,
    output req_packet_t            req_out [NUM_WAY],
    input  logic [NUM_WAY-1:0]     req_ack,
    input  ret_packet_t            ret_in [NUM_WAY],
    output logic [NUM_WAY-1:0]     ret_ack,
    output logic                   done,
    output logic                   error
);

    localparam int TIMER_WIDTH = $clog2(TIMEOUT_CYCLES + 1);

    logic                   running;
    logic                   start_run;
    logic                   write_fire;
    logic [BLOCK_WIDTH-1:0] run_pattern;
    logic [ADDR_WIDTH-1:0]  run_addr;
    logic [NUM_WAY-1:0]     req_valid;
    logic [NUM_WAY-1:0]     done_way;
    logic [NUM_WAY-1:0]     error_way;

    assign start_run  = start & ~running & ~error; // ignored mid-run and after an error.
    assign write_fire = req_valid[0] & req_ack[0];
    assign done       = &done_way;
    assign error      = |error_way;

    // pattern and address are latched for the whole run.
    always_ff @(posedge clk_in)
    begin
        if (start_run)
        begin
            run_pattern <= pattern;
            run_addr    <= base_addr;
        end
    end

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            running <= 1'b0;
        end
        else if (!error)
        begin
            if (start_run)
            begin
                running <= 1'b1;
            end
            else if (done)
            begin
                running <= 1'b0;
            end
        end
    end

    for (genvar w = 0; w < NUM_WAY; w++)
    begin : g_way
        localparam bit IS_WRITER = (w == 0);

        logic                   trigger;
        logic                   waiting;
        logic                   busy;
        logic                   finish;
        logic                   ret_fire;
        logic                   mismatch;
        logic [TIMER_WIDTH-1:0] timer;

        // way 0 starts on the pulse, readers start once the write is taken.
        assign trigger  = IS_WRITER ? start_run : write_fire;
        assign ret_fire = ret_in[w].valid & ret_ack[w];
        assign mismatch = ret_in[w].data != run_pattern;
        assign busy     = req_valid[w] | waiting;
        assign finish   = IS_WRITER ? (req_valid[w] & req_ack[w]) : ret_fire;

        assign req_out[w] = '{
            valid:     req_valid[w],
            cacheable: 1'b1,
            write:     IS_WRITER,
            port:      port_id_t'(w),
            byte_mask: {BYTE_MASK_WIDTH{IS_WRITER}},
            data:      run_pattern & {BLOCK_WIDTH{IS_WRITER}},
            addr:      run_addr
        };

        always_ff @(posedge clk_in or posedge reset_in)
        begin
            if (reset_in)
            begin
                req_valid[w] <= 1'b0;
                waiting      <= 1'b0;
                ret_ack[w]   <= 1'b0;
                done_way[w]  <= 1'b0;
                error_way[w] <= 1'b0;
                timer        <= '0;
            end
            else if (!error) // everything freezes once a way fails.
            begin
                if (start_run)
                begin
                    done_way[w] <= 1'b0;
                end
                if (trigger)
                begin
                    req_valid[w] <= 1'b1;
                    timer        <= '0;
                end
                else if (req_valid[w] && req_ack[w])
                begin
                    req_valid[w] <= 1'b0;
                    if (IS_WRITER)
                    begin
                        done_way[w] <= 1'b1;
                    end
                    else
                    begin
                        waiting <= 1'b1;
                    end
                end
                if (waiting)
                begin
                    ret_ack[w] <= ret_in[w].valid & ~ret_ack[w]; // one cycle behind valid.
                    if (ret_fire)
                    begin
                        waiting      <= 1'b0;
                        done_way[w]  <= ~mismatch;
                        error_way[w] <= mismatch;
                    end
                end
                if (busy && !finish)
                begin
                    timer <= timer + 1'b1;
                    if (timer >= TIMER_WIDTH'(TIMEOUT_CYCLES))
                    begin
                        error_way[w] <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== cache_selftest_top.sv ====
module cache_selftest_top import cache_pkg::*;
#(
    parameter int NUM_WAY        = 2,
    parameter int NUM_SETS       = 16,
    parameter int TIMEOUT_CYCLES = 100000
)
(
    input  logic                   clk_in,
    input  logic                   reset_in,
    input  logic                   start,
    input  logic [BLOCK_WIDTH-1:0] pattern,
    input  logic [ADDR_WIDTH-1:0]  base_addr,
    input  logic                   stall,
    input  logic [ADDR_WIDTH-1:0]  peek_addr,
    output logic [BLOCK_WIDTH-1:0] peek_data,
    output logic                   done,
    output logic                   error
);

    req_packet_t        way_req [NUM_WAY];
    logic [NUM_WAY-1:0] way_req_ack;
    ret_packet_t        way_ret [NUM_WAY];
    logic [NUM_WAY-1:0] way_ret_ack;

    cache_req_if req_bus ();
    cache_ret_if ret_bus ();

    cache_packet_generator #(
        .NUM_WAY        (NUM_WAY),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) i_generator (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .start     (start),
        .pattern   (pattern),
        .base_addr (base_addr),
        .req_out   (way_req),
        .req_ack   (way_req_ack),
        .ret_in    (way_ret),
        .ret_ack   (way_ret_ack),
        .done      (done),
        .error     (error)
    );

    request_arbiter #(.NUM_WAY(NUM_WAY)) i_arbiter (
        .req_in  (way_req),
        .req_ack (way_req_ack),
        .mem     (req_bus.arbiter)
    );

    block_store #(.NUM_SETS(NUM_SETS)) i_store (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .stall     (stall),
        .req       (req_bus.store),
        .ret       (ret_bus.store),
        .peek_addr (peek_addr),
        .peek_data (peek_data)
    );

    return_router #(.NUM_WAY(NUM_WAY)) i_router (
        .ret     (ret_bus.router),
        .ret_out (way_ret),
        .ret_ack (way_ret_ack)
    );

endmodule

// ==== cache_selftest_properties.sv ====
module cache_selftest_properties import cache_pkg::*;
(
    input logic        clk_in,
    input logic        reset_in,
    input req_packet_t req,
    input logic        req_ack,
    input ret_packet_t ret,
    input logic        ret_ack,
    input logic        done,
    input logic        error
);
    timeunit 1ns;
    timeprecision 100ps;

    int failure_count = 0; // read by the testbench.

    req_held: assert property (@(posedge clk_in) disable iff (reset_in)
        (req.valid && !req_ack) |=> $stable(req))
    else
    begin
        failure_count++;
        $error("request packet changed while waiting for its ack");
    end

    ret_held: assert property (@(posedge clk_in) disable iff (reset_in)
        (ret.valid && !ret_ack) |=> $stable(ret))
    else
    begin
        failure_count++;
        $error("return packet changed while waiting for its ack");
    end

    status_exclusive: assert property (@(posedge clk_in) disable iff (reset_in)
        !(done && error))
    else
    begin
        failure_count++;
        $error("done and error are high together");
    end
endmodule

bind cache_selftest_top cache_selftest_properties i_properties
(
    .clk_in   (clk_in),
    .reset_in (reset_in),
    .req      (req_bus.req),
    .req_ack  (req_bus.ack),
    .ret      (ret_bus.ret),
    .ret_ack  (ret_bus.ack),
    .done     (done),
    .error    (error)
);

// ==== tb_clock_gen.sv ====
module tb_clock_gen
(
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period.
    end

    // reset held for four cycles, released on a falling edge.
    initial
    begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end
endmodule

// ==== tb_cache_selftest.sv ====
module tb_cache_selftest import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int CYCLE_LIMIT    = 2000; // all tests together need a few hundred cycles.

    logic                   clk;
    logic                   por_reset;
    logic                   tb_reset;
    logic                   start;
    logic [BLOCK_WIDTH-1:0] pattern;
    logic [ADDR_WIDTH-1:0]  base_addr;
    logic                   stall;
    logic [ADDR_WIDTH-1:0]  peek_addr;
    logic [BLOCK_WIDTH-1:0] peek_data;
    logic                   done;
    logic                   error;
    int                     seed        = 28;
    int                     cycle_count = 0;

    tb_clock_gen i_clock_gen (.clk(clk), .reset(por_reset));

    cache_selftest_top #(.NUM_WAY(2), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_dut (
        .clk_in    (clk),
        .reset_in  (por_reset | tb_reset),
        .start     (start),
        .pattern   (pattern),
        .base_addr (base_addr),
        .stall     (stall),
        .peek_addr (peek_addr),
        .peek_data (peek_data),
        .done      (done),
        .error     (error)
    );

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // a bound assertion that fired ends the run at once.
    always @(negedge clk)
    begin
        if (i_dut.i_properties.failure_count != 0)
        begin
            $display("an assertion on the DUT handshakes or status failed");
            $display("Checks failed");
            $fatal(1, "assertion failure");
        end
    end

    task automatic check_value(input logic [BLOCK_WIDTH-1:0] actual,
                               input logic [BLOCK_WIDTH-1:0] expected, input string what);
        if (actual !== expected)
        begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [BLOCK_WIDTH-1:0] random_block();
        logic [BLOCK_WIDTH-1:0] value;
        for (int i = 0; i < BLOCK_WIDTH / 32; i++)
        begin
            value[i*32 +: 32] = $random(seed);
        end
        return value;
    endfunction

    // called on a falling edge, returns on the falling edge after the start edge.
    task automatic pulse_start(input logic [BLOCK_WIDTH-1:0] pat,
                               input logic [ADDR_WIDTH-1:0]  addr);
        pattern   = pat;
        base_addr = addr;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_for_end(output int cycles);
        cycles = 0;
        while (!done && !error)
        begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic check_peek(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [BLOCK_WIDTH-1:0] expected, input string what);
        peek_addr = addr;
        @(negedge clk);
        check_value(peek_data, expected, what);
    endtask

    task automatic apply_reset();
        tb_reset = 1'b1;
        repeat (4) @(negedge clk);
        tb_reset = 1'b0;
        @(negedge clk);
    endtask

    task automatic run_and_check(input logic [BLOCK_WIDTH-1:0] pat,
                                 input logic [ADDR_WIDTH-1:0]  addr);
        int cycles;
        pulse_start(pat, addr);
        check_value(done, 1'b0, "done cleared by start");
        wait_for_end(cycles);
        check_value(error, 1'b0, "error after a clean run");
        check_value(done, 1'b1, "done after a clean run");
        check_peek(addr, pat, "stored block after the run");
    endtask

    task automatic test_idle_after_reset();
        check_value(done, 1'b0, "done right after reset");
        check_value(error, 1'b0, "error right after reset");
        repeat (5) @(negedge clk);
        check_value(done, 1'b0, "done while idle");
        check_value(error, 1'b0, "error while idle");
    endtask

    task automatic test_two_sets();
        logic [ADDR_WIDTH-1:0]  addr_a;
        logic [ADDR_WIDTH-1:0]  addr_b;
        logic [BLOCK_WIDTH-1:0] pat_a;
        logic [BLOCK_WIDTH-1:0] pat_b;
        addr_a = $random(seed);
        addr_b = addr_a ^ 32'h0000_0050; // set index moves, offset stays.
        pat_a  = random_block();
        pat_b  = random_block();
        run_and_check(pat_a, addr_a);
        run_and_check(pat_b, addr_b);
        check_peek(addr_a, pat_a, "first set after second run");
        check_peek(addr_b, pat_b, "second set after second run");
    endtask

    task automatic test_short_stall();
        logic [BLOCK_WIDTH-1:0] pat;
        logic [ADDR_WIDTH-1:0]  addr;
        int                     cycles;
        pat  = random_block();
        addr = $random(seed);
        pulse_start(pat, addr);
        stall = 1'b1;
        repeat (20) @(negedge clk);
        check_value(done, 1'b0, "done while the bank is busy");
        check_value(error, 1'b0, "error during a short stall");
        stall = 1'b0;
        wait_for_end(cycles);
        check_value(error, 1'b0, "error after a short stall");
        check_value(done, 1'b1, "done after a short stall");
        check_peek(addr, pat, "stored block after a short stall");
    endtask

    task automatic test_long_stall();
        int cycles;
        stall = 1'b1;
        pulse_start(random_block(), $random(seed));
        wait_for_end(cycles);
        check_value(error, 1'b1, "error after a long stall");
        check_value(done, 1'b0, "done after a long stall");
        check_value(cycles >= TIMEOUT_CYCLES, 1'b1, "timeout not before the limit");
        repeat (10) @(negedge clk);
        stall = 1'b0;
        pulse_start(random_block(), $random(seed)); // must be ignored.
        repeat (10) @(negedge clk);
        check_value(error, 1'b1, "error is sticky");
        check_value(done, 1'b0, "done stays low after error");
        apply_reset();
        check_value(error, 1'b0, "error cleared by reset");
        check_value(done, 1'b0, "done cleared by reset");
        run_and_check(random_block(), $random(seed));
    endtask

    initial
    begin
        tb_reset  = 1'b0;
        start     = 1'b0;
        pattern   = '0;
        base_addr = '0;
        stall     = 1'b0;
        peek_addr = '0;
        @(negedge por_reset);
        @(negedge clk);
        test_idle_after_reset();
        run_and_check(random_block(), $random(seed));
        test_two_sets();
        test_short_stall();
        test_long_stall();
        if (i_dut.i_properties.failure_count != 0)
        begin
            $display("assertion failures were reported during the run");
            $display("Checks failed");
            $fatal(1, "assertion failures");
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end
endmodule

// ==== cache_selftest_top.f ====
cache_pkg.sv
cache_req_if.sv
cache_ret_if.sv
request_arbiter.sv
block_store.sv
return_router.sv
cache_packet_generator.sv
cache_selftest_top.sv
cache_selftest_properties.sv
tb_clock_gen.sv
tb_cache_selftest.sv

// ==== Makefile ====
BUILD = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_cache_selftest -f cache_selftest_top.f \
		-Mdir $(BUILD) -o sim_cache_selftest

run: compile
	./$(BUILD)/sim_cache_selftest +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf $(BUILD) sim.log
